//--- run_sim.sh
#!/bin/sh
# Build the bus subsystem testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing -f tb.f --top-module bus_subsystem_tb -o bus_subsystem_sim
status=$?
if [ "$status" -ne 0 ]; then
        echo "Verilator build failed with status $status"
        exit 1
fi

./obj_dir/bus_subsystem_sim > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ "$status" -ne 0 ]; then
        echo "Simulation exited with status $status"
        exit 1
fi

if grep -q "Checks failed" "$log_file"; then
        echo "Simulation reported failures, see $log_file"
        exit 1
fi

echo "Simulation finished without failures"
exit 0

//--- source/address_decoder.sv
// Registered address decoder routing each master request to one slave port set

`timescale 1ns/1ns

module address_decoder (
        input  logic           clock,
        input  logic           rst_n,
        input  bus_pkg::addr_t sb_address,
        input  logic           sb_write_strobe,
        input  logic           sb_read_strobe,
        input  bus_pkg::data_t sb_write_data,
        output bus_pkg::addr_t bank_address,
        output logic           bank_write_strobe,
        output logic           bank_read_strobe,
        output bus_pkg::data_t bank_write_data,
        output bus_pkg::addr_t ram_address,
        output logic           ram_write_strobe,
        output logic           ram_read_strobe,
        output bus_pkg::data_t ram_write_data
);

        logic [memory_map_pkg::slave_count-1:0] slave_hit;

        // Registered request towards each slave
        bus_pkg::addr_t req_address [memory_map_pkg::slave_count];
        logic           req_write_strobe [memory_map_pkg::slave_count];
        logic           req_read_strobe [memory_map_pkg::slave_count];
        bus_pkg::data_t req_write_data [memory_map_pkg::slave_count];

        for (genvar s = 0; s < memory_map_pkg::slave_count; s++) begin : g_slave
                // Base included, limit excluded
                assign slave_hit[s] = (sb_address >= memory_map_pkg::slave_base[s]) &&
                                      (sb_address < memory_map_pkg::slave_limit[s]);

                always_ff @(posedge clock or negedge rst_n) begin
                        if (!rst_n) begin
                                req_address[s] <= '0;
                                req_write_strobe[s] <= 1'b0;
                                req_read_strobe[s] <= 1'b0;
                                req_write_data[s] <= '0;
                        end else if (slave_hit[s]) begin
                                req_address[s] <= sb_address;
                                req_write_strobe[s] <= sb_write_strobe;
                                req_read_strobe[s] <= sb_read_strobe;
                                req_write_data[s] <= sb_write_data;
                        end else begin
                                // Unselected slaves see an all-zero request
                                req_address[s] <= '0;
                                req_write_strobe[s] <= 1'b0;
                                req_read_strobe[s] <= 1'b0;
                                req_write_data[s] <= '0;
                        end
                end
        end

        // Register bank port set
        assign bank_address = req_address[memory_map_pkg::register_slave];
        assign bank_write_strobe = req_write_strobe[memory_map_pkg::register_slave];
        assign bank_read_strobe = req_read_strobe[memory_map_pkg::register_slave];
        assign bank_write_data = req_write_data[memory_map_pkg::register_slave];

        // Scratch RAM port set
        assign ram_address = req_address[memory_map_pkg::ram_slave];
        assign ram_write_strobe = req_write_strobe[memory_map_pkg::ram_slave];
        assign ram_read_strobe = req_read_strobe[memory_map_pkg::ram_slave];
        assign ram_write_data = req_write_data[memory_map_pkg::ram_slave];

endmodule

//--- source/bus_pkg.sv
// Bus widths and the address, data and register index types of the strobe bus

package bus_pkg;

        // Widths of the master-side bus
        localparam int addr_width = 32;
        localparam int data_width = 32;

        // Byte address as driven by the master
        typedef logic [addr_width-1:0] addr_t;

        // Read and write data word
        typedef logic [data_width-1:0] data_t;

        // Register bank word index, from address bits 4 to 2
        typedef logic [2:0] reg_index_t;

        // Scratch RAM word index, from address bits 9 to 2
        typedef logic [7:0] ram_index_t;

endpackage

//--- source/bus_subsystem.sv
// Top level of the bus subsystem with decoder, register bank, scratch RAM and read return

`timescale 1ns/1ns

module bus_subsystem (
        input  logic           clock,
        input  logic           rst_n,
        input  bus_pkg::addr_t sb_address,
        input  logic           sb_write_strobe,
        input  logic           sb_read_strobe,
        input  bus_pkg::data_t sb_write_data,
        output bus_pkg::data_t sb_read_data,
        output logic           sb_ready
);

        // Register bank request and response
        bus_pkg::addr_t bank_address;
        logic           bank_write_strobe;
        logic           bank_read_strobe;
        bus_pkg::data_t bank_write_data;
        bus_pkg::data_t bank_read_data;
        logic           bank_ready;

        // Scratch RAM request and response
        bus_pkg::addr_t ram_address;
        logic           ram_write_strobe;
        logic           ram_read_strobe;
        bus_pkg::data_t ram_write_data;
        bus_pkg::data_t ram_read_data;
        logic           ram_ready;

        address_decoder decoder_i (
                .clock             (clock),
                .rst_n             (rst_n),
                .sb_address        (sb_address),
                .sb_write_strobe   (sb_write_strobe),
                .sb_read_strobe    (sb_read_strobe),
                .sb_write_data     (sb_write_data),
                .bank_address      (bank_address),
                .bank_write_strobe (bank_write_strobe),
                .bank_read_strobe  (bank_read_strobe),
                .bank_write_data   (bank_write_data),
                .ram_address       (ram_address),
                .ram_write_strobe  (ram_write_strobe),
                .ram_read_strobe   (ram_read_strobe),
                .ram_write_data    (ram_write_data)
        );

        register_bank bank_i (
                .clock        (clock),
                .rst_n        (rst_n),
                .address      (bank_address),
                .write_strobe (bank_write_strobe),
                .read_strobe  (bank_read_strobe),
                .write_data   (bank_write_data),
                .read_data    (bank_read_data),
                .ready        (bank_ready)
        );

        scratch_ram ram_i (
                .clock        (clock),
                .rst_n        (rst_n),
                .address      (ram_address),
                .write_strobe (ram_write_strobe),
                .read_strobe  (ram_read_strobe),
                .write_data   (ram_write_data),
                .read_data    (ram_read_data),
                .ready        (ram_ready)
        );

        read_return return_i (
                .clock          (clock),
                .rst_n          (rst_n),
                .bank_read_data (bank_read_data),
                .bank_ready     (bank_ready),
                .ram_read_data  (ram_read_data),
                .ram_ready      (ram_ready),
                .sb_read_data   (sb_read_data),
                .sb_ready       (sb_ready)
        );

endmodule

//--- source/memory_map_pkg.sv
// Slave count, slave index type, address windows and region sizes of the memory map

package memory_map_pkg;

        localparam int slave_count = 2;

        typedef logic [$clog2(slave_count)-1:0] slave_index_t;

        // Slot of each slave in the decoder and the window tables
        localparam slave_index_t register_slave = slave_index_t'(0);
        localparam slave_index_t ram_slave = slave_index_t'(1);

        // Region sizes in bytes
        localparam bus_pkg::addr_t register_bank_size = 32'h0000_0020;
        localparam bus_pkg::addr_t scratch_ram_size = 32'h0000_0400;

        // Half-open windows, base included and limit excluded
        localparam bus_pkg::addr_t register_bank_base = 32'h0000_0000;
        localparam bus_pkg::addr_t register_bank_limit = register_bank_base + register_bank_size;
        localparam bus_pkg::addr_t scratch_ram_base = 32'h0000_1000;
        localparam bus_pkg::addr_t scratch_ram_limit = scratch_ram_base + scratch_ram_size;

        // One 32-bit word per four bytes
        localparam int ram_words = scratch_ram_size / 4;

        // Window tables, element order follows register_slave and ram_slave
        localparam bus_pkg::addr_t [slave_count-1:0] slave_base =
                {scratch_ram_base, register_bank_base};
        localparam bus_pkg::addr_t [slave_count-1:0] slave_limit =
                {scratch_ram_limit, register_bank_limit};

endpackage

//--- source/read_return.sv
// Registered merge of slave read data and ready levels back to the master

`timescale 1ns/1ns

module read_return (
        input  logic           clock,
        input  logic           rst_n,
        input  bus_pkg::data_t bank_read_data,
        input  logic           bank_ready,
        input  bus_pkg::data_t ram_read_data,
        input  logic           ram_ready,
        output bus_pkg::data_t sb_read_data,
        output logic           sb_ready
);

        // Idle slaves drive zero data and high ready, so OR and AND
        // pick out the one slave that answers
        always_ff @(posedge clock or negedge rst_n) begin
                if (!rst_n) begin
                        sb_read_data <= '0;
                        sb_ready <= 1'b1;
                end else begin
                        sb_read_data <= bank_read_data | ram_read_data;
                        sb_ready <= bank_ready & ram_ready;
                end
        end

endmodule

//--- source/register_bank.sv
// Eight read/write control registers with a one-cycle registered read

`timescale 1ns/1ns

module register_bank (
        input  logic           clock,
        input  logic           rst_n,
        input  bus_pkg::addr_t address,
        input  logic           write_strobe,
        input  logic           read_strobe,
        input  bus_pkg::data_t write_data,
        output bus_pkg::data_t read_data,
        output logic           ready
);

        localparam int register_count = 8;

        bus_pkg::data_t     registers [register_count];
        bus_pkg::reg_index_t word_index;

        // Word address, byte offset dropped
        assign word_index = address[4:2];

        // Register file, cleared on reset
        always_ff @(posedge clock or negedge rst_n) begin
                if (!rst_n) begin
                        for (int i = 0; i < register_count; i++) begin
                                registers[i] <= '0;
                        end
                end else if (write_strobe) begin
                        registers[word_index] <= write_data;
                end
        end

        // Read data for one cycle only, zero otherwise so the OR merge works
        always_ff @(posedge clock or negedge rst_n) begin
                if (!rst_n) begin
                        read_data <= '0;
                end else if (read_strobe) begin
                        read_data <= registers[word_index];
                end else begin
                        read_data <= '0;
                end
        end

        // Never stalls the bus
        assign ready = 1'b1;

endmodule

//--- source/scratch_ram.sv
// Scratch RAM slave with a two-stage read pipeline and ready low while a read is in flight

`timescale 1ns/1ns

module scratch_ram (
        input  logic           clock,
        input  logic           rst_n,
        input  bus_pkg::addr_t address,
        input  logic           write_strobe,
        input  logic           read_strobe,
        input  bus_pkg::data_t write_data,
        output bus_pkg::data_t read_data,
        output logic           ready
);

        typedef enum logic [1:0] {
                idle,
                fetch,
                respond
        } ram_state_t;

        ram_state_t state;

        bus_pkg::data_t      memory [memory_map_pkg::ram_words];
        bus_pkg::ram_index_t word_index;
        bus_pkg::ram_index_t read_index;
        bus_pkg::data_t      hold_data;

        assign word_index = address[9:2];

        // Read FSM, a new access is only accepted in idle
        always_ff @(posedge clock or negedge rst_n) begin
                if (!rst_n) begin
                        state <= idle;
                end else begin
                        case (state)
                                idle: begin
                                        if (read_strobe) begin
                                                state <= fetch;
                                        end
                                end
                                fetch: begin
                                        state <= respond;
                                end
                                respond: begin
                                        state <= idle;
                                end
                                default: begin
                                        state <= idle;
                                end
                        endcase
                end
        end

        // Array and read path registers
        always_ff @(posedge clock) begin
                if (state == idle && write_strobe) begin
                        memory[word_index] <= write_data;
                end
                // Keep the index, the decoder drops the request after one cycle
                if (state == idle && read_strobe) begin
                        read_index <= word_index;
                end
                if (state == fetch) begin
                        hold_data <= memory[read_index];
                end
        end

        // Data appears only in the respond cycle
        assign read_data = (state == respond) ? hold_data : '0;

        // Busy through fetch and respond
        assign ready = (state == idle);

endmodule

//--- tb.f
source/bus_pkg.sv
source/memory_map_pkg.sv
source/address_decoder.sv
source/register_bank.sv
source/scratch_ram.sv
source/read_return.sv
source/bus_subsystem.sv
testbench/bus_subsystem_tb.sv

//--- testbench/bus_subsystem_tb.sv
// Testbench for the bus subsystem: clock, reset, golden vector access loop, checks and report

`timescale 1ns/1ns

module bus_subsystem_tb;

        localparam int region_bank = 0;
        localparam int region_ram = 1;
        localparam int region_none = 2;

        // Cycles watched after the edge that samples a strobe
        localparam int sample_cycles = 5;
        localparam int ready_timeout = 50;

        logic           clock;
        logic           rst_n;
        bus_pkg::addr_t sb_address;
        logic           sb_write_strobe;
        logic           sb_read_strobe;
        bus_pkg::data_t sb_write_data;
        bus_pkg::data_t sb_read_data;
        logic           sb_ready;

        int check_errors;
        int tests_passed;
        int tests_failed;

        bus_subsystem dut_i (
                .clock           (clock),
                .rst_n           (rst_n),
                .sb_address      (sb_address),
                .sb_write_strobe (sb_write_strobe),
                .sb_read_strobe  (sb_read_strobe),
                .sb_write_data   (sb_write_data),
                .sb_read_data    (sb_read_data),
                .sb_ready        (sb_ready)
        );

        // 8 ns period
        always #4 clock = ~clock;

        // Which slave answers an address, from the half-open windows
        function automatic int region_of(input bus_pkg::addr_t address);
                if (address >= memory_map_pkg::register_bank_base &&
                    address < memory_map_pkg::register_bank_limit) begin
                        return region_bank;
                end
                if (address >= memory_map_pkg::scratch_ram_base &&
                    address < memory_map_pkg::scratch_ram_limit) begin
                        return region_ram;
                end
                return region_none;
        endfunction

        task automatic check_data(input string name, input bus_pkg::data_t expected,
                                  input bus_pkg::data_t actual);
                if (actual !== expected) begin
                        $display("CHECK FAILED %s data expected %h actual %h",
                                 name, expected, actual);
                        check_errors++;
                end
        endtask

        task automatic check_ready(input string name, input logic expected, input logic actual);
                if (actual !== expected) begin
                        $display("CHECK FAILED %s ready expected %b actual %b",
                                 name, expected, actual);
                        check_errors++;
                end
        endtask

        // Called on a falling edge, returns on a falling edge with ready high
        task automatic wait_ready(input string name, output bit timed_out);
                int waited;
                waited = 0;
                timed_out = 1'b0;
                while (sb_ready !== 1'b1 && !timed_out) begin
                        if (waited == ready_timeout) begin
                                $display("Timed out after %0d cycles waiting for sb_ready before %s",
                                         ready_timeout, name);
                                timed_out = 1'b1;
                        end else begin
                                @(negedge clock);
                                waited++;
                        end
                end
        endtask

        task automatic report_test(input string name, input int errors_before,
                                   input bit timed_out);
                if (timed_out || check_errors != errors_before) begin
                        $display("FAIL %s", name);
                        tests_failed++;
                end else begin
                        $display("PASS %s", name);
                        tests_passed++;
                end
        endtask

        // One strobe, then the expected data and ready for each following cycle
        task automatic run_access(input logic [7:0] op, input bus_pkg::addr_t address,
                                  input bus_pkg::data_t data, input string name,
                                  output bit timed_out);
                int             region;
                int             latency;
                bus_pkg::data_t exp_data;
                logic           exp_ready;
                string          cycle_name;
                region = region_of(address);
                latency = 0;
                // Bank answers two cycles after the strobe, RAM three
                if (op == "R" && region == region_bank) begin
                        latency = 2;
                end
                if (op == "R" && region == region_ram) begin
                        latency = 3;
                end
                wait_ready(name, timed_out);
                if (!timed_out) begin
                        sb_address = address;
                        sb_write_strobe = (op == "W");
                        sb_read_strobe = (op == "R") || (op == "Z");
                        sb_write_data = (op == "W") ? data : '0;
                        @(negedge clock);
                        sb_address = '0;
                        sb_write_strobe = 1'b0;
                        sb_read_strobe = 1'b0;
                        sb_write_data = '0;
                        for (int k = 1; k <= sample_cycles; k++) begin
                                @(negedge clock);
                                cycle_name = $sformatf("%s cycle %0d", name, k);
                                exp_data = (k == latency) ? data : '0;
                                // RAM read holds ready low in the second and third cycle
                                exp_ready = !(op == "R" && region == region_ram &&
                                              (k == 2 || k == 3));
                                check_data(cycle_name, exp_data, sb_read_data);
                                check_ready(cycle_name, exp_ready, sb_ready);
                        end
                end
        endtask

        initial begin
                int             fd;
                int             line_no;
                int             fields;
                int             errors_before;
                string          line;
                string          name;
                logic [7:0]     op;
                bus_pkg::addr_t address;
                bus_pkg::data_t data;
                bit             timed_out;

                clock = 1'b0;
                rst_n = 1'b0;
                sb_address = '0;
                sb_write_strobe = 1'b0;
                sb_read_strobe = 1'b0;
                sb_write_data = '0;
                check_errors = 0;
                tests_passed = 0;
                tests_failed = 0;
                line_no = 0;
                timed_out = 1'b0;

                repeat (3) @(posedge clock);
                @(negedge clock);
                rst_n = 1'b1;
                @(negedge clock);

                // Idle bus straight after reset
                errors_before = check_errors;
                check_ready("reset", 1'b1, sb_ready);
                check_data("reset", '0, sb_read_data);
                report_test("reset", errors_before, 1'b0);

                fd = $fopen("testbench/golden_vectors.txt", "r");
                if (fd == 0) begin
                        $display("Could not open testbench/golden_vectors.txt for reading");
                        tests_failed++;
                end else begin
                        while (!timed_out && $fgets(line, fd) != 0) begin
                                line_no++;
                                if (line.len() < 2 || line.getc(0) == "#") begin
                                        continue;
                                end
                                fields = $sscanf(line, "%c %h %h", op, address, data);
                                name = $sformatf("line %0d %c %h", line_no, op, address);
                                if (fields != 3) begin
                                        $display("Golden file line %0d has %0d fields, not 3",
                                                 line_no, fields);
                                        tests_failed++;
                                end else if (op != "W" && op != "R" && op != "Z") begin
                                        $display("Golden file line %0d has unknown operation %c",
                                                 line_no, op);
                                        tests_failed++;
                                end else begin
                                        errors_before = check_errors;
                                        run_access(op, address, data, name, timed_out);
                                        report_test(name, errors_before, timed_out);
                                end
                        end
                        $fclose(fd);
                end

                $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
                if (tests_failed == 0 && check_errors == 0) begin
                        $display("All checks passed");
                end else begin
                        $display("Checks failed");
                end
                $finish;
        end

endmodule

//--- testbench/golden_vectors.txt
# Columns: operation (W write, R read, Z read expecting zero), address in hex, data in hex
# W data is written, R data is the expected read data, Z data is ignored
W 00000000 11111111
W 00000004 a5a5a5a5
W 0000000c 00c0ffee
W 0000001c 7e57da7a
R 00000004 a5a5a5a5
R 00000000 11111111
R 0000001c 7e57da7a
R 0000000c 00c0ffee
R 00000008 00000000
# Scratch RAM at low, middle and top words
W 00001000 0badf00d
W 00001200 12345678
W 000013fc fedcba98
R 00001000 0badf00d
R 000013fc fedcba98
R 00001200 12345678
# Both limits are outside the windows
W 00000020 deadbeef
W 00001400 cafef00d
R 00000000 11111111
R 00001000 0badf00d
Z 00000020 00000000
Z 00001400 00000000
# Unmapped space
Z 00000800 00000000
Z 00000ffc 00000000
Z 00002000 00000000
Z ffffffff 00000000
# RAM traffic leaves the registers alone
W 00001004 aaaa5555
R 00001004 aaaa5555
R 00000004 a5a5a5a5
W 00001008 00000000
R 000013fc fedcba98
R 00001008 00000000
R 0000001c 7e57da7a
R 0000000c 00c0ffee
W 00000010 5a5a0f0f
R 00001200 12345678
R 00000010 5a5a0f0f
R 00000000 11111111
